/* verilog/ooo_pkg.sv */
package ooo_pkg;

    // Major opcodes accepted by dispatch
    localparam logic [6:0] opc_op     = 7'b0110011;  // Register-register arithmetic
    localparam logic [6:0] opc_op_imm = 7'b0010011;  // Register-immediate arithmetic

    localparam logic [2:0] f3_add = 3'b000;          // add sub addi mul
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_or  = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;

    localparam logic [6:0] f7_base   = 7'b0000000;   // Plain R-type
    localparam logic [6:0] f7_alt    = 7'b0100000;   // Selects sub
    localparam logic [6:0] f7_muldiv = 7'b0000001;   // M extension group

    localparam logic unit_alu = 1'b0;                // Issue goes to the ALU
    localparam logic unit_mul = 1'b1;                // Issue goes to the multiplier

    // One 32-bit word seen as R-type or I-type fields
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
    } inst_word_u;

    typedef enum logic [2:0] {alu_add, alu_sub, alu_and, alu_or, alu_xor} alu_op_e;

endpackage

/* verilog/arch_regfile.sv */
`timescale 1ns/1ns

module arch_regfile (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  rs1_addr,
    input  logic [4:0]  rs2_addr,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data,
    input  logic        commit_valid,
    input  logic        commit_we,
    input  logic [4:0]  commit_dest,
    input  logic [31:0] commit_value
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < 32; r++)
                regs[r] <= 32'd0;
        end else if (commit_valid && commit_we && commit_dest != 5'd0) begin
            regs[commit_dest] <= commit_value;       // In-order architectural update
        end
    end

    // x0 is forced on the read side as well
    assign rs1_data = (rs1_addr == 5'd0) ? 32'd0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? 32'd0 : regs[rs2_addr];

endmodule

/* verilog/alu_unit.sv */
`timescale 1ns/1ns

module alu_unit #(
    parameter int tag_width = 3
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 flush,
    input  logic                 iss_valid,
    input  logic                 iss_unit,
    input  ooo_pkg::alu_op_e     iss_op,
    input  logic [tag_width-1:0] iss_tag,
    input  logic [31:0]          iss_a,
    input  logic [31:0]          iss_b,
    output logic                 alu_done,
    output logic [tag_width-1:0] alu_tag,
    output logic [31:0]          alu_value
);

    logic        take;                               // Issue is addressed to this unit
    logic [31:0] result;

    assign take = iss_valid & (iss_unit == ooo_pkg::unit_alu);

    always_comb begin
        case (iss_op)
            ooo_pkg::alu_add: result = iss_a + iss_b;
            ooo_pkg::alu_sub: result = iss_a - iss_b;
            ooo_pkg::alu_and: result = iss_a & iss_b;
            ooo_pkg::alu_or:  result = iss_a | iss_b;
            ooo_pkg::alu_xor: result = iss_a ^ iss_b;
            default:          result = 32'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush)
            alu_done <= 1'b0;                        // Kill anything in the result slot
        else
            alu_done <= take;
    end

    always_ff @(posedge clk) begin
        if (take) begin
            alu_tag   <= iss_tag;                    // Tag rides with the value
            alu_value <= result;
        end
    end

endmodule

/* verilog/mul_unit.sv */
`timescale 1ns/1ns

module mul_unit #(
    parameter int tag_width = 3
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 flush,
    input  logic                 iss_valid,
    input  logic                 iss_unit,
    input  logic [tag_width-1:0] iss_tag,
    input  logic [31:0]          iss_a,
    input  logic [31:0]          iss_b,
    output logic                 mul_done,
    output logic [tag_width-1:0] mul_tag,
    output logic [31:0]          mul_value
);

    logic                 take;
    logic                 s1_valid;                  // Stage 1 operand capture
    logic [tag_width-1:0] s1_tag;
    logic [31:0]          s1_a;
    logic [31:0]          s1_b;
    logic                 s2_valid;                  // Stage 2 full product
    logic [tag_width-1:0] s2_tag;
    logic [63:0]          s2_prod;

    assign take = iss_valid & (iss_unit == ooo_pkg::unit_mul);

    // Valids only; up to three multiplies in flight
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            mul_done <= 1'b0;
        end else begin
            s1_valid <= take;
            s2_valid <= s1_valid;
            mul_done <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_tag    <= iss_tag;
        s1_a      <= iss_a;
        s1_b      <= iss_b;
        s2_tag    <= s1_tag;
        s2_prod   <= s1_a * s1_b;                    // 32 by 32 into 64
        mul_tag   <= s2_tag;
        mul_value <= s2_prod[31:0];                  // Low word is the same signed or unsigned
    end

endmodule

/* verilog/dispatch_stage.sv */
`timescale 1ns/1ns

module dispatch_stage #(
    parameter int tag_width = 3
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  logic [31:0]          in_inst,
    input  logic [31:0]          in_pc,
    input  logic                 full,
    input  logic [31:0]          pending,
    input  logic                 flush,
    output logic                 alloc,
    output logic [4:0]           alloc_dest,
    output logic                 alloc_we,
    output logic                 alloc_exc,
    output logic [31:0]          alloc_pc,
    input  logic [tag_width-1:0] alloc_tag,
    output logic [4:0]           rs1_addr,
    output logic [4:0]           rs2_addr,
    input  logic [31:0]          rs1_data,
    input  logic [31:0]          rs2_data,
    output logic                 iss_valid,
    output logic                 iss_unit,
    output ooo_pkg::alu_op_e     iss_op,
    output logic [tag_width-1:0] iss_tag,
    output logic [31:0]          iss_a,
    output logic [31:0]          iss_b
);

    ooo_pkg::inst_word_u word;                       // Incoming word in both views
    ooo_pkg::alu_op_e    dec_op;                     // Decoded ALU operation
    ooo_pkg::alu_op_e    f3_op;                      // Operation implied by funct3 alone
    logic                f3_ok;                      // funct3 is one of the supported four
    logic                legal;
    logic                dec_unit;
    logic                is_imm;
    logic                uses_rs2;
    logic                hazard;
    logic                exc_pend;                   // Illegal word accepted, flush not seen yet

    assign word = in_inst;

    always_comb begin
        f3_ok = 1'b1;
        f3_op = ooo_pkg::alu_add;
        case (word.i.funct3)
            ooo_pkg::f3_add: f3_op = ooo_pkg::alu_add;
            ooo_pkg::f3_xor: f3_op = ooo_pkg::alu_xor;
            ooo_pkg::f3_or:  f3_op = ooo_pkg::alu_or;
            ooo_pkg::f3_and: f3_op = ooo_pkg::alu_and;
            default:         f3_ok = 1'b0;       // Shifts and compares are outside the subset
        endcase
    end

    always_comb begin
        legal    = 1'b0;
        dec_unit = ooo_pkg::unit_alu;
        dec_op   = f3_op;
        is_imm   = 1'b0;
        uses_rs2 = 1'b0;
        if (word.r.opcode == ooo_pkg::opc_op) begin
            uses_rs2 = 1'b1;
            if (word.r.funct7 == ooo_pkg::f7_base) begin
                legal = f3_ok;                           // add xor or and
            end else if (word.r.funct7 == ooo_pkg::f7_alt && word.r.funct3 == ooo_pkg::f3_add) begin
                legal  = 1'b1;
                dec_op = ooo_pkg::alu_sub;
            end else if (word.r.funct7 == ooo_pkg::f7_muldiv
                         && word.r.funct3 == ooo_pkg::f3_add) begin
                legal    = 1'b1;
                dec_unit = ooo_pkg::unit_mul;
            end
        end else if (word.i.opcode == ooo_pkg::opc_op_imm) begin
            is_imm = 1'b1;
            legal  = f3_ok;                              // addi xori ori andi
        end
    end

    assign rs1_addr = word.r.rs1;
    assign rs2_addr = word.r.rs2;

    // RAW check against writes still in flight; illegal words read nothing
    assign hazard   = legal & (pending[rs1_addr] | (uses_rs2 & pending[rs2_addr]));
    assign in_ready = ~full & ~hazard & ~exc_pend;

    assign alloc      = in_valid & in_ready;
    assign alloc_dest = word.r.rd;
    assign alloc_we   = legal & (word.r.rd != 5'd0);     // x0 writes are dropped at commit
    assign alloc_exc  = ~legal;
    assign alloc_pc   = in_pc;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            exc_pend  <= 1'b0;
            iss_valid <= 1'b0;
        end else begin
            if (alloc && !legal)
                exc_pend <= 1'b1;                        // Hold off younger words
            iss_valid <= alloc & legal;                  // Illegal entry gets no issue
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            iss_unit <= dec_unit;
            iss_op   <= dec_op;
            iss_tag  <= alloc_tag;
            iss_a    <= rs1_data;
            iss_b    <= is_imm ? {{20{word.i.imm[11]}}, word.i.imm} : rs2_data;
        end
    end

endmodule

/* verilog/reorder_buffer.sv */
`timescale 1ns/1ns

module reorder_buffer #(
    parameter int rob_depth = 8,
    parameter int tag_width = 3
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 alloc,
    input  logic [4:0]           alloc_dest,
    input  logic                 alloc_we,
    input  logic                 alloc_exc,
    input  logic [31:0]          alloc_pc,
    output logic [tag_width-1:0] alloc_tag,
    output logic                 full,
    output logic [31:0]          pending,
    input  logic                 alu_done,
    input  logic [tag_width-1:0] alu_tag,
    input  logic [31:0]          alu_value,
    input  logic                 mul_done,
    input  logic [tag_width-1:0] mul_tag,
    input  logic [31:0]          mul_value,
    output logic                 commit_valid,
    output logic [4:0]           commit_dest,
    output logic [31:0]          commit_value,
    output logic                 commit_we,
    output logic                 exc_valid,
    output logic [31:0]          exc_pc,
    output logic                 flush
);

    logic [rob_depth-1:0] busy;                      // Slot holds an instruction
    logic [rob_depth-1:0] done;                      // Value present or exception known
    logic [rob_depth-1:0] exc;
    logic [rob_depth-1:0] we;
    logic [4:0]           dest  [rob_depth];
    logic [31:0]          value [rob_depth];
    logic [31:0]          pc    [rob_depth];
    logic [tag_width-1:0] head;                      // Oldest entry
    logic [tag_width-1:0] tail;                      // Next free slot
    logic [tag_width:0]   count;
    logic [tag_width:0]   wr_cnt [32];               // In-flight writers per register
    logic [31:0]          wr_inc;
    logic [31:0]          wr_dec;
    logic                 head_ready;
    logic                 head_commit;
    logic                 head_exc;

    assign alloc_tag   = tail;
    assign full        = (count == (tag_width + 1)'(rob_depth));
    assign head_ready  = busy[head] & done[head];
    assign head_commit = head_ready & ~exc[head];
    assign head_exc    = head_ready & exc[head];         // Flush instead of commit

    always_ff @(posedge clk) begin
        if (rst || head_exc) begin
            busy         <= '0;
            done         <= '0;
            exc          <= '0;
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            commit_valid <= 1'b0;
            exc_valid    <= ~rst;                    // Pulse only on the exception path
            flush        <= ~rst;
        end else begin
            commit_valid <= head_commit;
            exc_valid    <= 1'b0;
            flush        <= 1'b0;
            if (alloc) begin
                busy[tail] <= 1'b1;
                done[tail] <= alloc_exc;             // Exception entry needs no unit
                exc[tail]  <= alloc_exc;
                tail       <= tail + 1'b1;
            end
            if (alu_done && busy[alu_tag])
                done[alu_tag] <= 1'b1;
            if (mul_done && busy[mul_tag])
                done[mul_tag] <= 1'b1;               // Both ports may land together
            if (head_commit) begin
                busy[head] <= 1'b0;
                head       <= head + 1'b1;
            end
            count <= count + (tag_width + 1)'(alloc) - (tag_width + 1)'(head_commit);
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            we[tail]   <= alloc_we;
            dest[tail] <= alloc_dest;
            pc[tail]   <= alloc_pc;
        end
        if (alu_done)
            value[alu_tag] <= alu_value;
        if (mul_done)
            value[mul_tag] <= mul_value;
        if (head_commit) begin
            commit_dest  <= dest[head];
            commit_value <= value[head];
            commit_we    <= we[head];
        end
        if (head_exc)
            exc_pc <= pc[head];
    end

    // Writer released when the register file takes the value
    assign wr_inc = (alloc && alloc_we) ? (32'd1 << alloc_dest) : 32'd0;
    assign wr_dec = (commit_valid && commit_we) ? (32'd1 << commit_dest) : 32'd0;

    always_ff @(posedge clk) begin
        for (int r = 0; r < 32; r++) begin
            if (rst || head_exc)
                wr_cnt[r] <= '0;
            else if (wr_inc[r] && !wr_dec[r])
                wr_cnt[r] <= wr_cnt[r] + 1'b1;
            else if (wr_dec[r] && !wr_inc[r])
                wr_cnt[r] <= wr_cnt[r] - 1'b1;
        end
    end

    always_comb begin
        for (int r = 0; r < 32; r++)
            pending[r] = (wr_cnt[r] != '0);          // Any older writer still open
    end

endmodule

/* verilog/ooo_core_top.sv */
`timescale 1ns/1ns

module ooo_core_top #(
    parameter int rob_depth = 8,
    parameter int tag_width = 3                      // log2 of rob_depth
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    output logic        in_ready,
    input  logic [31:0] in_inst,
    input  logic [31:0] in_pc,
    output logic        commit_valid,
    output logic [4:0]  commit_dest,
    output logic [31:0] commit_value,
    output logic        commit_we,
    output logic        exc_valid,
    output logic [31:0] exc_pc
);

    logic                 full;
    logic [31:0]          pending;
    logic                 flush;
    logic                 alloc;
    logic [4:0]           alloc_dest;
    logic                 alloc_we;
    logic                 alloc_exc;
    logic [31:0]          alloc_pc;
    logic [tag_width-1:0] alloc_tag;
    logic [4:0]           rs1_addr;
    logic [4:0]           rs2_addr;
    logic [31:0]          rs1_data;
    logic [31:0]          rs2_data;
    logic                 iss_valid;                 // Issue bus to both units
    logic                 iss_unit;
    ooo_pkg::alu_op_e     iss_op;
    logic [tag_width-1:0] iss_tag;
    logic [31:0]          iss_a;
    logic [31:0]          iss_b;
    logic                 alu_done;
    logic [tag_width-1:0] alu_tag;
    logic [31:0]          alu_value;
    logic                 mul_done;
    logic [tag_width-1:0] mul_tag;
    logic [31:0]          mul_value;

    dispatch_stage #(.tag_width(tag_width)) u_dispatch (
        .clk, .rst, .in_valid, .in_ready, .in_inst, .in_pc, .full, .pending, .flush,
        .alloc, .alloc_dest, .alloc_we, .alloc_exc, .alloc_pc, .alloc_tag,
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .iss_valid, .iss_unit, .iss_op, .iss_tag, .iss_a, .iss_b
    );

    alu_unit #(.tag_width(tag_width)) u_alu (
        .clk, .rst, .flush, .iss_valid, .iss_unit, .iss_op, .iss_tag, .iss_a, .iss_b,
        .alu_done, .alu_tag, .alu_value
    );

    mul_unit #(.tag_width(tag_width)) u_mul (
        .clk, .rst, .flush, .iss_valid, .iss_unit, .iss_tag, .iss_a, .iss_b,
        .mul_done, .mul_tag, .mul_value
    );

    reorder_buffer #(.rob_depth(rob_depth), .tag_width(tag_width)) u_rob (
        .clk, .rst, .alloc, .alloc_dest, .alloc_we, .alloc_exc, .alloc_pc, .alloc_tag,
        .full, .pending, .alu_done, .alu_tag, .alu_value, .mul_done, .mul_tag, .mul_value,
        .commit_valid, .commit_dest, .commit_value, .commit_we, .exc_valid, .exc_pc, .flush
    );

    arch_regfile u_regfile (
        .clk, .rst, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .commit_valid, .commit_we, .commit_dest, .commit_value
    );

endmodule

/* bench/ooo_core_chk.sv */
`timescale 1ns/1ns

module ooo_core_chk (
    input logic        clk,
    input logic        rst,
    input logic        in_valid,
    input logic        in_ready,
    input logic [31:0] in_inst,
    input logic [31:0] in_pc,
    input logic        commit_valid,
    input logic        exc_valid
);

    int fail_count = 0;                                  // Bumped by every failing property

    // Retire side carries either a commit or an exception, never both
    commit_exc_excl: assert property (@(posedge clk) disable iff (rst)
        !(commit_valid && exc_valid))
        else begin
            $error("commit_valid and exc_valid are high in the same cycle");
            fail_count++;
        end

    input_held: assert property (@(posedge clk) disable iff (rst)
        (in_valid && !in_ready) |=> (in_valid && $stable(in_inst) && $stable(in_pc)))
        else begin
            $error("in_inst or in_pc changed while the instruction waited");
            fail_count++;
        end

    ready_after_reset: assert property (@(posedge clk) $fell(rst) |-> in_ready)
        else begin
            $error("in_ready is low in the first cycle after reset");
            fail_count++;
        end

endmodule

bind ooo_core_top ooo_core_chk u_chk (
    .clk(clk), .rst(rst), .in_valid(in_valid), .in_ready(in_ready), .in_inst(in_inst),
    .in_pc(in_pc), .commit_valid(commit_valid), .exc_valid(exc_valid)
);

/* bench/ooo_core_tb.sv */
`timescale 1ns/1ns

module ooo_core_tb;

    localparam int rob_depth  = 4;                       // Small buffer so a multiply burst backs up
    localparam int tag_width  = 2;
    localparam int clk_period = 40;
    localparam int max_rows   = 64;

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic        in_ready;
    logic [31:0] in_inst;
    logic [31:0] in_pc;
    logic        commit_valid;
    logic [4:0]  commit_dest;
    logic [31:0] commit_value;
    logic        commit_we;
    logic        exc_valid;
    logic [31:0] exc_pc;

    logic [31:0] tab_inst  [max_rows];                   // Stimulus columns
    logic [31:0] tab_pc    [max_rows];
    logic        tab_burst [max_rows];                   // No in_valid gap before this row
    logic        exp_exc   [max_rows];                   // Expected columns, filled by the model
    logic [4:0]  exp_dest  [max_rows];
    logic        exp_we    [max_rows];
    logic [31:0] exp_value [max_rows];
    logic [31:0] shadow    [32];                         // Model register file
    int          exp_q[$];                               // Rows still to retire, oldest first
    int          n_rows;
    integer      seed;
    logic        saw_full;                               // Burst row saw in_ready low

    ooo_core_top #(.rob_depth(rob_depth), .tag_width(tag_width)) UUT (
        .clk, .rst, .in_valid, .in_ready, .in_inst, .in_pc,
        .commit_valid, .commit_dest, .commit_value, .commit_we, .exc_valid, .exc_pc
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic fail_now(string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp)
            fail_now($sformatf("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp));
    endtask

    task automatic check_dest(string name, logic [4:0] got, logic [4:0] exp);
        if (got !== exp)
            fail_now($sformatf("ERROR at %0t ns: %s is %0d, expected %0d", $time, name, got, exp));
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp)
            fail_now($sformatf("ERROR at %0t ns: %s is %b, expected %b", $time, name, got, exp));
    endtask

    task automatic check_pc(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp)
            fail_now($sformatf("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp));
    endtask

    // Word builders go through the R and I views of the instruction union
    function automatic logic [31:0] encode_r(logic [6:0] f7, logic [2:0] f3,
                                             logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
        ooo_pkg::inst_word_u w;
        w.r.funct7 = f7;
        w.r.rs2    = rs2;
        w.r.rs1    = rs1;
        w.r.funct3 = f3;
        w.r.rd     = rd;
        w.r.opcode = ooo_pkg::opc_op;
        return w;
    endfunction

    function automatic logic [31:0] encode_i(logic [6:0] opc, logic [2:0] f3,
                                             logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        ooo_pkg::inst_word_u w;
        w.i.imm    = imm;
        w.i.rs1    = rs1;
        w.i.funct3 = f3;
        w.i.rd     = rd;
        w.i.opcode = opc;                                // Any opcode, so illegal words fit too
        return w;
    endfunction

    task automatic add_row(logic [31:0] word, logic burst);
        tab_inst[n_rows]  = word;
        tab_pc[n_rows]    = 32'h0000_1000 + 32'(n_rows * 4);
        tab_burst[n_rows] = burst;
        n_rows++;
    endtask

    task automatic build_table();
        logic [6:0] opi;
        logic [6:0] fb;
        logic [6:0] fm;
        opi = ooo_pkg::opc_op_imm;
        fb  = ooo_pkg::f7_base;
        fm  = ooo_pkg::f7_muldiv;
        add_row(encode_i(opi, ooo_pkg::f3_add, 5'd1, 5'd0, 12'd5), 1'b0);     // addi x1
        add_row(encode_i(opi, ooo_pkg::f3_add, 5'd2, 5'd0, 12'hffd), 1'b0);   // Negative imm
        add_row(encode_i(opi, ooo_pkg::f3_or,  5'd3, 5'd0, 12'h0f0), 1'b0);
        add_row(encode_i(opi, ooo_pkg::f3_xor, 5'd4, 5'd0, 12'h7ff), 1'b0);
        add_row(encode_i(opi, ooo_pkg::f3_and, 5'd5, 5'd0, 12'h7ff), 1'b0);
        add_row(encode_i(opi, ooo_pkg::f3_add, 5'd6, 5'd0, 12'h800), 1'b0);   // Most negative imm
        add_row(encode_r(fb, ooo_pkg::f3_add, 5'd7, 5'd1, 5'd2), 1'b0);
        add_row(encode_r(ooo_pkg::f7_alt, ooo_pkg::f3_add, 5'd8, 5'd7, 5'd1), 1'b0); // RAW on x7
        add_row(encode_r(fb, ooo_pkg::f3_and, 5'd9, 5'd3, 5'd4), 1'b0);
        add_row(encode_r(fb, ooo_pkg::f3_or,  5'd10, 5'd3, 5'd4), 1'b0);
        add_row(encode_r(fb, ooo_pkg::f3_xor, 5'd11, 5'd3, 5'd4), 1'b0);
        add_row(encode_r(fm, ooo_pkg::f3_add, 5'd12, 5'd2, 5'd6), 1'b0);     // mul, then ALU work
        add_row(encode_i(opi, ooo_pkg::f3_add, 5'd13, 5'd0, 12'd100), 1'b0);
        add_row(encode_i(opi, ooo_pkg::f3_xor, 5'd14, 5'd1, 12'h555), 1'b0);
        add_row(encode_r(fm, ooo_pkg::f3_add, 5'd15, 5'd12, 5'd8), 1'b0);    // Waits on x12
        add_row(encode_r(fb, ooo_pkg::f3_add, 5'd16, 5'd15, 5'd13), 1'b0);
        add_row(encode_i(opi, ooo_pkg::f3_add, 5'd0, 5'd1, 12'd9), 1'b0);    // Write to x0
        add_row(encode_r(fb, ooo_pkg::f3_add, 5'd17, 5'd0, 5'd1), 1'b0);
        add_row(encode_r(fb, ooo_pkg::f3_or,  5'd0, 5'd3, 5'd4), 1'b0);
        add_row(encode_i(opi, ooo_pkg::f3_xor, 5'd18, 5'd0, 12'h123), 1'b0);
        add_row(encode_r(fm, ooo_pkg::f3_add, 5'd19, 5'd1, 5'd1), 1'b0);     // Older than the trap
        add_row(encode_i(opi, 3'b001, 5'd20, 5'd1, 12'h004), 1'b0);          // slli, illegal
        add_row(encode_i(opi, ooo_pkg::f3_add, 5'd20, 5'd19, 12'd1), 1'b0);
        add_row(encode_r(ooo_pkg::f7_alt, ooo_pkg::f3_add, 5'd21, 5'd20, 5'd2), 1'b0);
        add_row(encode_i(7'b0000011, 3'b010, 5'd22, 5'd2, 12'h010), 1'b0);   // lw, illegal
        add_row(encode_r(fb, ooo_pkg::f3_add, 5'd22, 5'd21, 5'd20), 1'b0);
        add_row(encode_r(fm, ooo_pkg::f3_add, 5'd23, 5'd1, 5'd2), 1'b1);     // Burst of muls
        add_row(encode_r(fm, ooo_pkg::f3_add, 5'd24, 5'd2, 5'd3), 1'b1);
        add_row(encode_r(fm, ooo_pkg::f3_add, 5'd25, 5'd3, 5'd13), 1'b1);
        add_row(encode_r(fm, ooo_pkg::f3_add, 5'd26, 5'd13, 5'd1), 1'b1);
        add_row(encode_r(fm, ooo_pkg::f3_add, 5'd27, 5'd4, 5'd1), 1'b1);
        add_row(encode_r(fm, ooo_pkg::f3_add, 5'd28, 5'd6, 5'd2), 1'b1);
        add_row(encode_r(fm, ooo_pkg::f3_add, 5'd29, 5'd17, 5'd18), 1'b1);
        add_row(encode_r(fm, ooo_pkg::f3_add, 5'd30, 5'd10, 5'd1), 1'b1);
        add_row(encode_r(fm, ooo_pkg::f3_add, 5'd31, 5'd9, 5'd2), 1'b1);
        add_row(encode_r(fm, ooo_pkg::f3_add, 5'd23, 5'd11, 5'd1), 1'b1);    // Second writer of x23
        add_row(encode_r(fm, ooo_pkg::f3_add, 5'd24, 5'd14, 5'd13), 1'b1);
        add_row(encode_r(fm, ooo_pkg::f3_add, 5'd25, 5'd16, 5'd1), 1'b1);
        add_row(encode_r(fb, ooo_pkg::f3_add, 5'd1, 5'd23, 5'd24), 1'b0);
        add_row(encode_r(fb, ooo_pkg::f3_xor, 5'd2, 5'd1, 5'd25), 1'b0);
    endtask

    // In-order execution of one word against the shadow registers
    task automatic model_row(input logic [31:0] inst, output logic ok, output logic [4:0] rd,
                             output logic we, output logic [31:0] val);
        ooo_pkg::inst_word_u w;
        logic [31:0] a;
        logic [31:0] b;
        w   = inst;
        ok  = 1'b0;
        val = 32'd0;
        rd  = w.r.rd;
        a   = shadow[w.r.rs1];
        b   = shadow[w.r.rs2];
        if (w.r.opcode == ooo_pkg::opc_op) begin
            if (w.r.funct7 == ooo_pkg::f7_base) begin
                ok = 1'b1;
                case (w.r.funct3)
                    ooo_pkg::f3_add: val = a + b;
                    ooo_pkg::f3_xor: val = a ^ b;
                    ooo_pkg::f3_or:  val = a | b;
                    ooo_pkg::f3_and: val = a & b;
                    default:         ok  = 1'b0;
                endcase
            end else if (w.r.funct7 == ooo_pkg::f7_alt && w.r.funct3 == ooo_pkg::f3_add) begin
                ok  = 1'b1;
                val = a - b;
            end else if (w.r.funct7 == ooo_pkg::f7_muldiv && w.r.funct3 == ooo_pkg::f3_add) begin
                ok  = 1'b1;
                val = a * b;                             // Low 32 bits only
            end
        end else if (w.i.opcode == ooo_pkg::opc_op_imm) begin
            b  = {{20{w.i.imm[11]}}, w.i.imm};
            ok = 1'b1;
            case (w.i.funct3)
                ooo_pkg::f3_add: val = a + b;
                ooo_pkg::f3_xor: val = a ^ b;
                ooo_pkg::f3_or:  val = a | b;
                ooo_pkg::f3_and: val = a & b;
                default:         ok  = 1'b0;         // Shifts and compares trap
            endcase
        end
        we = ok && (rd != 5'd0);
        if (we)
            shadow[rd] = val;
    endtask

    // Retire monitor, sampled on the rising edge before the DUT updates
    always @(posedge clk) begin
        int idx;
        if (!rst && (commit_valid || exc_valid)) begin
            if (exp_q.size() == 0) begin
                fail_now("A commit or exception appeared after every instruction had retired");
            end else begin
                idx = exp_q.pop_front();
                check_flag("exc_valid", exc_valid, exp_exc[idx]);
                if (exp_exc[idx]) begin
                    check_pc("exc_pc", exc_pc, tab_pc[idx]);
                end else begin
                    check_dest("commit_dest", commit_dest, exp_dest[idx]);
                    check_flag("commit_we", commit_we, exp_we[idx]);
                    check_value("commit_value", commit_value, exp_value[idx]);
                end
            end
        end
    end

    always @(posedge clk) begin
        if (UUT.u_chk.fail_count != 0)
            fail_now("A protocol assertion on the core ports failed");
    end

    initial begin
        logic        ok;
        logic [4:0]  rd;
        logic        we;
        logic [31:0] val;
        int          gap;
        clk      = 1'b0;
        rst      = 1'b1;
        in_valid = 1'b0;
        in_inst  = 32'd0;
        in_pc    = 32'd0;
        seed     = 32'heb66_0c90;
        saw_full = 1'b0;
        n_rows   = 0;
        for (int r = 0; r < 32; r++)
            shadow[r] = 32'd0;
        build_table();
        for (int i = 0; i < n_rows; i++) begin
            model_row(tab_inst[i], ok, rd, we, val);
            exp_exc[i]   = ~ok;                          // Trap row, architectural state untouched
            exp_dest[i]  = rd;
            exp_we[i]    = we;
            exp_value[i] = val;
            exp_q.push_back(i);
        end
        fork
            begin
                #((n_rows * 40 + 100) * clk_period);
                fail_now("Timeout: the core stopped retiring instructions");
            end
        join_none
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < n_rows; i++) begin
            if (!tab_burst[i]) begin
                gap      = $unsigned($random(seed)) % 3;
                in_valid = 1'b0;
                repeat (gap) @(negedge clk);
            end
            in_valid = 1'b1;
            in_inst  = tab_inst[i];
            in_pc    = tab_pc[i];
            @(posedge clk);
            while (!in_ready) begin
                if (tab_burst[i])
                    saw_full = 1'b1;                     // Burst has no hazards, so this is full
                @(posedge clk);
            end
            @(negedge clk);
        end
        in_valid = 1'b0;
        while (exp_q.size() != 0)
            @(posedge clk);
        repeat (10) @(posedge clk);                      // Catch any extra retire
        if (!saw_full) begin
            fail_now("The reorder buffer never filled during the multiply burst");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

/* all.f */
verilog/ooo_pkg.sv
verilog/arch_regfile.sv
verilog/alu_unit.sv
verilog/mul_unit.sv
verilog/dispatch_stage.sv
verilog/reorder_buffer.sv
verilog/ooo_core_top.sv
bench/ooo_core_chk.sv
bench/ooo_core_tb.sv

/* Bender.yml */
package:
  name: ooo_core

sources:
  - verilog/ooo_pkg.sv
  - verilog/arch_regfile.sv
  - verilog/alu_unit.sv
  - verilog/mul_unit.sv
  - verilog/dispatch_stage.sv
  - verilog/reorder_buffer.sv
  - verilog/ooo_core_top.sv
  - target: test
    files:
      - bench/ooo_core_chk.sv
      - bench/ooo_core_tb.sv
